// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = avg_tb
FILELIST = vlog.f
RUNFLAGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(RUNFLAGS)); echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

// File: sim/avg_properties.sv
`timescale 1ns/1ps

module avg_properties #(
   parameter int DIVIDEND_W = 12
) (
   input logic                clk,
   input logic                rstn,
   input avg_pkg::avg_state_t state,
   input logic                start,
   input logic                done,
   input logic                drop,
   input logic                avg_valid
);

   import avg_pkg::*;

   int unsigned fail_cnt = 0;   // Failed assertions so far
   logic        in_div;         // Start seen, done not yet passed

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn)
         in_div <= 1'b0;
      else if (start)
         in_div <= 1'b1;
      else if (done)
         in_div <= 1'b0;
   end

   assert property (@(posedge clk) disable iff (!rstn) avg_valid |=> !avg_valid)
      else begin
         $error("avg_valid high for two cycles in a row");
         fail_cnt++;
      end

   // Divider answers a fixed number of cycles after start
   assert property (@(posedge clk) disable iff (!rstn) start |-> ##DIVIDEND_W done)
      else begin
         $error("done missing %0d cycles after start", DIVIDEND_W);
         fail_cnt++;
      end

   assert property (@(posedge clk) disable iff (!rstn) start |-> !in_div)
      else begin
         $error("start raised while a divide is running");
         fail_cnt++;
      end

   // Divider is busy from start to done inclusive
   assert property (@(posedge clk) disable iff (!rstn) drop |-> (start || in_div))
      else begin
         $error("drop outside of a divide");
         fail_cnt++;
      end

   assert property (@(posedge clk) disable iff (!rstn) in_div |-> (state == DIVIDING))
      else begin
         $error("averager left DIVIDING before done");
         fail_cnt++;
      end

endmodule

bind sample_avg avg_properties #(.DIVIDEND_W(SUM_W)) props0 (
   .clk, .rstn, .state, .start, .done(div.done), .drop, .avg_valid
);

// File: sim/avg_tb.sv
`timescale 1ns/1ps

module avg_tb;

   import avg_pkg::*;

   localparam int WIDTH       = 8;
   localparam int MAX_SAMPLES = 16;
   localparam int SEED        = 32378;
   localparam int TIMEOUT     = 100;   // Cycles, well above the divide latency

   logic                  clk;
   logic                  rstn;
   logic                  psel, penable, pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [apb_data_w-1:0] pwdata, prdata;
   logic                  pready, pslverr;
   logic [WIDTH-1:0]      data_in;
   logic                  dvalid;
   logic [WIDTH-1:0]      avg_out;
   logic                  avg_valid;

   logic [WIDTH-1:0] sent_q[$];
   logic [WIDTH-1:0] exp_q[$];
   logic [WIDTH-1:0] last_exp;
   int               last_len;
   int               exp_total;
   int               results;
   int               errors;

   avg_top #(.WIDTH(WIDTH), .MAX_SAMPLES(MAX_SAMPLES)) dut0 (.*);

   always #2 clk = ~clk;

   // Floor of sum over count, cut to the sample width
   function automatic logic [WIDTH-1:0] ref_avg(input logic [WIDTH-1:0] smp[$]);
      int sum;
      sum = 0;
      foreach (smp[i])
         sum += int'(smp[i]);
      return WIDTH'(sum / smp.size());
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      err     = pslverr;
      check("pready", pready, 1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      data    = prdata;
      err     = pslverr;
      check("pready", pready, 1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic send_burst(input int n, input bit expect_result);
      logic [WIDTH-1:0] d;
      int               i;
      sent_q.delete();
      for (i = 0; i < n; i++) begin
         d = WIDTH'($urandom);
         @(posedge clk);
         #1;
         dvalid  = 1'b1;
         data_in = d;
         if (sent_q.size() < MAX_SAMPLES)   // Burst closes at the cap
            sent_q.push_back(d);
      end
      @(posedge clk);
      #1;
      dvalid = 1'b0;
      if (expect_result) begin
         last_exp = ref_avg(sent_q);
         last_len = sent_q.size();
         exp_q.push_back(last_exp);
         exp_total++;
      end
   endtask

   task automatic wait_results();
      int cyc;
      cyc = 0;
      while (results < exp_total && cyc < TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      if (results < exp_total) begin
         $display("Timeout while waiting for avg_valid after a burst");
         errors++;
      end
   endtask

   // Result checker, one expected average per closed burst
   initial begin
      int idle;
      idle = 0;
      forever begin
         @(negedge clk);
         if (avg_valid === 1'b1) begin
            results++;
            idle = 0;
            if (exp_q.size() == 0) begin
               $display("avg_valid came with no burst outstanding");
               errors++;
            end else begin
               check("avg_out", avg_out, exp_q.pop_front());
            end
         end else if (exp_q.size() != 0) begin
            idle++;
            if (idle > TIMEOUT) begin
               $display("Timeout, a closed burst never produced avg_valid");
               errors++;
               void'(exp_q.pop_front());
               idle = 0;
            end
         end
      end
   end

   initial begin
      logic [31:0] rdata;
      logic        err;
      int          drops;
      int          n;
      int          b;
      int          total;
      clk       = 1'b0;
      rstn      = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      data_in   = '0;
      dvalid    = 1'b0;
      errors    = 0;
      results   = 0;
      exp_total = 0;
      void'($urandom(SEED));
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;

      // Disabled, so the burst is ignored
      send_burst(5, 1'b0);
      repeat (TIMEOUT) @(posedge clk);
      check("results", results, 0);
      apb_read(REG_RESULT_CNT, rdata, err);
      check("RESULT_CNT", rdata, 0);

      apb_write(REG_CTRL, 32'h1, err);
      check("pslverr", err, 0);
      for (b = 0; b < 8; b++) begin
         n = 1 + ($urandom % 10);
         send_burst(n, 1'b1);
         wait_results();
         apb_read(REG_LAST_AVG, rdata, err);
         check("LAST_AVG", rdata, last_exp);
         apb_read(REG_LAST_CNT, rdata, err);
         check("LAST_CNT", rdata, last_len);
      end

      // Long burst hits the cap, the tail is dropped
      apb_read(REG_DROP_CNT, rdata, err);
      drops = rdata;
      send_burst(20, 1'b1);
      wait_results();
      repeat (TIMEOUT) @(posedge clk);
      check("results", results, exp_total);
      apb_read(REG_DROP_CNT, rdata, err);
      check("DROP_CNT", rdata, drops + 20 - MAX_SAMPLES);
      apb_read(REG_LAST_CNT, rdata, err);
      check("LAST_CNT", rdata, MAX_SAMPLES);

      // Lone sample two cycles after the gap lands in the divide
      apb_read(REG_DROP_CNT, rdata, err);
      drops = rdata;
      send_burst(3, 1'b1);
      @(posedge clk);
      @(posedge clk);
      #1;
      dvalid  = 1'b1;
      data_in = WIDTH'($urandom);
      @(posedge clk);
      #1;
      dvalid = 1'b0;
      apb_read(REG_STATUS, rdata, err);
      check("STATUS", rdata, 1);
      wait_results();
      apb_read(REG_STATUS, rdata, err);
      check("STATUS", rdata, 0);
      apb_read(REG_DROP_CNT, rdata, err);
      check("DROP_CNT", rdata, drops + 1);
      apb_read(REG_RESULT_CNT, rdata, err);
      check("RESULT_CNT", rdata, exp_total);

      apb_write(REG_STATUS, 32'hFF, err);
      check("pslverr", err, 1);
      apb_read(5'h1C, rdata, err);
      check("pslverr", err, 1);
      check("prdata", rdata, 0);
      apb_read(REG_CTRL, rdata, err);
      check("pslverr", err, 0);
      check("CTRL", rdata, 1);

      total = errors + int'(dut0.avg0.props0.fail_cnt);
      $display("Errors: %0d checks, %0d assertions, %0d results", errors,
               dut0.avg0.props0.fail_cnt, results);
      if (total == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: src/avg_divider.sv
`timescale 1ns/1ps

module avg_divider #(
   parameter int DIVIDEND_W = 12,
   parameter int DIVISOR_W  = 5
) (
   input logic   clk,
   input logic   rstn,
   div_if.server div
);

   import avg_pkg::*;

   localparam int BIT_W = $clog2(DIVIDEND_W);
   localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DIVIDEND_W - 1);

   div_state_t            state;
   logic [BIT_W-1:0]      bit_cnt;
   logic                  done_q;
   logic                  step;
   logic [DIVISOR_W-1:0]  rem_q, rem_in;
   logic [DIVISOR_W-1:0]  dvs_q, dvs_in;
   logic [DIVISOR_W:0]    rem_sh, rem_nxt;
   logic [DIVIDEND_W-1:0] acc_q, acc_in, acc_nxt;

   // First quotient bit is already formed in the start cycle
   assign step = (state == DIV_RUN) || (state == DIV_IDLE && div.start);

   always_comb begin
      if (state == DIV_IDLE) begin
         rem_in = '0;
         acc_in = div.dividend;
         dvs_in = div.divisor;
      end else begin
         rem_in = rem_q;
         acc_in = acc_q;
         dvs_in = dvs_q;
      end
      rem_sh = {rem_in, acc_in[DIVIDEND_W-1]};   // Bring down next dividend bit
      if (rem_sh >= {1'b0, dvs_in}) begin
         rem_nxt = rem_sh - {1'b0, dvs_in};
         acc_nxt = {acc_in[DIVIDEND_W-2:0], 1'b1};
      end else begin
         rem_nxt = rem_sh;                       // Restore
         acc_nxt = {acc_in[DIVIDEND_W-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state   <= DIV_IDLE;
         bit_cnt <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            DIV_IDLE: if (div.start) begin
               state   <= DIV_RUN;
               bit_cnt <= BIT_W'(1);
            end
            DIV_RUN: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == LAST_BIT) begin
                  state  <= DIV_IDLE;
                  done_q <= 1'b1;          // Last bit lands with done
               end
            end
            default: state <= DIV_IDLE;
         endcase
      end
   end

   // Remainder and shifting dividend/quotient
   always_ff @(posedge clk) begin
      if (step) begin
         rem_q <= rem_nxt[DIVISOR_W-1:0];
         acc_q <= acc_nxt;
         dvs_q <= dvs_in;
      end
   end

   assign div.done     = done_q;
   assign div.quotient = acc_q;

endmodule

// File: src/avg_pkg.sv
package avg_pkg;

   localparam int apb_addr_w = 5;
   localparam int apb_data_w = 32;

   typedef enum logic [1:0] {IDLE, ACCUMULATING, DIVIDING, AVG_OUT} avg_state_t;

   typedef enum logic {DIV_IDLE, DIV_RUN} div_state_t;

   // Byte addresses of the APB registers
   typedef enum logic [apb_addr_w-1:0] {
      REG_CTRL       = 5'h00,
      REG_STATUS     = 5'h04,
      REG_LAST_AVG   = 5'h08,
      REG_LAST_CNT   = 5'h0C,
      REG_RESULT_CNT = 5'h10,
      REG_DROP_CNT   = 5'h14
   } reg_addr_t;

   // Sum must hold MAX_SAMPLES full-scale samples
   function automatic int sum_width(input int width, input int max_samples);
      return $clog2(((2 ** width) - 1) * max_samples + 1);
   endfunction

   function automatic int cnt_width(input int max_samples);
      return $clog2(max_samples + 1);   // Count reaches max_samples itself
   endfunction

endpackage

// File: src/avg_regs.sv
`timescale 1ns/1ps

module avg_regs #(
   parameter int WIDTH = 8,
   parameter int CNT_W = 10
) (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [avg_pkg::apb_addr_w-1:0] paddr,
   input  logic [avg_pkg::apb_data_w-1:0] pwdata,
   output logic [avg_pkg::apb_data_w-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   output logic                           enable,
   input  logic                           busy,
   input  logic                           avg_valid,
   input  logic [WIDTH-1:0]               avg_out,
   input  logic [CNT_W-1:0]               avg_cnt,
   input  logic                           drop
);

   import avg_pkg::*;

   reg_addr_t             addr;
   logic                  access;
   logic                  mapped;
   logic                  read_only;
   logic                  wr;
   logic [apb_data_w-1:0] rd_data;
   logic [WIDTH-1:0]      last_avg;
   logic [CNT_W-1:0]      last_cnt;
   logic [apb_data_w-1:0] result_cnt;
   logic [apb_data_w-1:0] drop_cnt;

   assign addr   = reg_addr_t'(paddr);
   assign access = psel && penable;

   always_comb begin
      mapped    = 1'b1;
      read_only = 1'b1;
      rd_data   = '0;
      case (addr)
         REG_CTRL: begin
            read_only = 1'b0;
            rd_data   = apb_data_w'(enable);
         end
         REG_STATUS:     rd_data = apb_data_w'(busy);
         REG_LAST_AVG:   rd_data = apb_data_w'(last_avg);
         REG_LAST_CNT:   rd_data = apb_data_w'(last_cnt);
         REG_RESULT_CNT: rd_data = result_cnt;
         REG_DROP_CNT:   rd_data = drop_cnt;
         default:        mapped = 1'b0;
      endcase
   end

   assign wr      = access && pwrite && mapped && !read_only;
   assign pready  = 1'b1;   // No wait states
   assign pslverr = access && (!mapped || (pwrite && read_only));
   assign prdata  = (access && !pwrite) ? rd_data : '0;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         enable     <= 1'b0;
         last_avg   <= '0;
         last_cnt   <= '0;
         result_cnt <= '0;
         drop_cnt   <= '0;
      end else begin
         if (wr)
            enable <= pwdata[0];
         if (avg_valid) begin
            last_avg   <= avg_out;
            last_cnt   <= avg_cnt;
            result_cnt <= result_cnt + 1'b1;   // Wraps
         end
         if (drop)
            drop_cnt <= drop_cnt + 1'b1;
      end
   end

endmodule

// File: src/avg_top.sv
`timescale 1ns/1ps

module avg_top #(
   parameter int WIDTH       = 8,
   parameter int MAX_SAMPLES = 1000
) (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [avg_pkg::apb_addr_w-1:0] paddr,
   input  logic [avg_pkg::apb_data_w-1:0] pwdata,
   output logic [avg_pkg::apb_data_w-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   input  logic [WIDTH-1:0]               data_in,
   input  logic                           dvalid,
   output logic [WIDTH-1:0]               avg_out,
   output logic                           avg_valid
);

   import avg_pkg::*;

   localparam int SUM_W = sum_width(WIDTH, MAX_SAMPLES);
   localparam int CNT_W = cnt_width(MAX_SAMPLES);

   logic             enable;
   logic             busy;
   logic             drop;
   logic [CNT_W-1:0] avg_cnt;

   div_if #(.DIVIDEND_W(SUM_W), .DIVISOR_W(CNT_W)) div0 ();

   sample_avg #(.WIDTH(WIDTH), .MAX_SAMPLES(MAX_SAMPLES)) avg0 (
      .clk,
      .rstn,
      .data_in,
      .dvalid,
      .enable,
      .div       (div0.client),
      .avg_out,
      .avg_valid,
      .avg_cnt,
      .busy,
      .drop
   );

   avg_divider #(.DIVIDEND_W(SUM_W), .DIVISOR_W(CNT_W)) divider0 (
      .clk,
      .rstn,
      .div (div0.server)
   );

   avg_regs #(.WIDTH(WIDTH), .CNT_W(CNT_W)) regs0 (
      .clk,
      .rstn,
      .psel,
      .penable,
      .pwrite,
      .paddr,
      .pwdata,
      .prdata,
      .pready,
      .pslverr,
      .enable,
      .busy,
      .avg_valid,
      .avg_out,
      .avg_cnt,
      .drop
   );

endmodule

// File: src/div_if.sv
`timescale 1ns/1ps

interface div_if #(
   parameter int DIVIDEND_W = 12,
   parameter int DIVISOR_W  = 5
);

   logic                  start;
   logic [DIVIDEND_W-1:0] dividend;
   logic [DIVISOR_W-1:0]  divisor;
   logic                  done;
   logic [DIVIDEND_W-1:0] quotient;

   modport client (output start, dividend, divisor, input done, quotient);

   modport server (input start, dividend, divisor, output done, quotient);

endinterface

// File: src/sample_avg.sv
`timescale 1ns/1ps

module sample_avg #(
   parameter int WIDTH       = 8,
   parameter int MAX_SAMPLES = 1000
) (
   input  logic                                        clk,
   input  logic                                        rstn,
   input  logic [WIDTH-1:0]                            data_in,
   input  logic                                        dvalid,
   input  logic                                        enable,
   div_if.client                                       div,
   output logic [WIDTH-1:0]                            avg_out,
   output logic                                        avg_valid,
   output logic [avg_pkg::cnt_width(MAX_SAMPLES)-1:0]  avg_cnt,
   output logic                                        busy,
   output logic                                        drop
);

   import avg_pkg::*;

   localparam int SUM_W = sum_width(WIDTH, MAX_SAMPLES);
   localparam int CNT_W = cnt_width(MAX_SAMPLES);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(MAX_SAMPLES - 1);

   avg_state_t       state, next;
   logic [SUM_W-1:0] sum, sum_base;
   logic [CNT_W-1:0] cnt, cnt_base;
   logic             accept;
   logic             last;
   logic             close;
   logic             start;

   assign busy   = (state == DIVIDING);
   assign accept = dvalid && enable && !busy;
   assign drop   = dvalid && enable && busy;   // One pulse per lost sample

   // A new burst restarts from zero, also straight out of AVG_OUT
   assign cnt_base = (state == ACCUMULATING) ? cnt : '0;
   assign sum_base = (state == ACCUMULATING) ? sum : '0;
   assign last     = accept && (cnt_base == LAST_CNT);

   always_comb begin
      next = state;
      case (state)
         IDLE, AVG_OUT: begin
            if (last)
               next = DIVIDING;
            else if (accept)
               next = ACCUMULATING;
            else
               next = IDLE;
         end
         ACCUMULATING: if (last || !accept) next = DIVIDING;   // Cap or gap
         DIVIDING:     if (div.done) next = AVG_OUT;
         default:      next = IDLE;
      endcase
   end

   assign close = (next == DIVIDING) && !busy;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= IDLE;
         start <= 1'b0;
      end else begin
         state <= next;
         start <= close;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         sum <= sum_base + SUM_W'(data_in);
         cnt <= cnt_base + 1'b1;
      end
      if (div.done) begin
         avg_out <= div.quotient[WIDTH-1:0];
         avg_cnt <= cnt;
      end
   end

   assign avg_valid = (state == AVG_OUT);

   // Sum and count stay frozen for the whole divide
   assign div.start    = start;
   assign div.dividend = sum;
   assign div.divisor  = cnt;

endmodule

// File: vlog.f
src/avg_pkg.sv
src/div_if.sv
src/avg_divider.sv
src/sample_avg.sv
src/avg_regs.sv
src/avg_top.sv
sim/avg_properties.sv
sim/avg_tb.sv
